// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_bus_mapper
RTL_TOP   ?= bus_mapper
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/clk_gen.sv ====
// Testbench clock and reset source: free running clock, reset held for a few cycles
`timescale 1ns/100ps

module clk_gen #(
    parameter real PERIOD     = 100.0,
    parameter int  RST_CYCLES = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    // release falls on a falling clock edge
    initial begin
        rst = 1'b1;
        #(PERIOD * RST_CYCLES);
        rst = 1'b0;
    end

endmodule

// ==== bench/tb_bus_mapper.sv ====
// Bus mapper testbench that drives the CPU, MCU and sound sides and checks them against a model
`timescale 1ns/100ps
`include "mapper_defs.svh"

module tb_bus_mapper import mapper_pkg::*; ();

    localparam int N_ADDR    = 24;
    localparam int N_ITEMS   = 6 + N_ADDR;
    localparam int LIMIT_CYC = 40 * N_ITEMS + 300;
    localparam int SETTLE    = 10;
    // register accesses use a top byte that no programmed base can reach
    localparam logic [7:0] REG_TOP = 8'hff;

    logic        clk, rst;
    logic        cpu_cen = 1'b0;
    logic        pxl_cen = 1'b1;
    logic        vint, bus_busy, sndmap_rd, mcu_wr;
    cpu_bus_t    bus;
    logic [15:0] mcu_addr;
    logic [7:0]  mcu_dout;
    logic        cpu_rst, cpu_haltn, cpu_dtackn, cpu_vpan, sndmap_obf;
    logic [2:0]  cpu_ipln;
    logic [7:0]  sndmap_dout, mcu_din, active;
    logic [1:0]  mcu_intn;
    logic [23:1] addr_out;
    logic [15:0] bus_din;

    integer      seed = 80;
    int          errors, checks, tests_run, test_errors;
    string       test_name;
    // model copies of what was written
    logic [7:0]  reg_base [`MAP_REGIONS];
    logic [7:0]  reg_size [`MAP_REGIONS];
    logic [7:0]  snd_val;
    logic [7:0]  wd [2];
    logic [7:0]  wa [3];
    logic [7:0]  ra [3];

    clk_gen #(.PERIOD(100.0), .RST_CYCLES(2)) u_clk (.clk(clk), .rst(rst));

    bus_mapper dut0 (.*);

    // cpu clock enable on every second cycle
    always @(negedge clk) begin
        cpu_cen <= ~cpu_cen;
    end

    // AS high at one edge leaves every DTACK stage released by the next
    assert property (@(posedge clk) disable iff (rst) bus.asn |=> cpu_dtackn)
    else begin
        $display("CHECK FAILED %s: cpu_dtackn after AS high expected 1 actual %b",
                 test_name, $sampled(cpu_dtackn));
        errors++;
    end

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (exp === act)
        else begin
            $display("CHECK FAILED %s: %s expected %h actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = errors;
        @(negedge clk);
    endtask

    task automatic finish_test();
        tests_run++;
        $display("%-10s finished with %0d error(s)", test_name, errors - test_errors);
    endtask

    task automatic bus_idle();
        bus.asn  = 1'b1;
        bus.dsn  = 2'b11;
        bus.dswn = 2'b11;
        bus.fc   = 3'b101;
        bus.addr = {REG_TOP, 15'd0};
        bus.dout = '0;
    endtask

    // one clock of write strobe starting on a falling edge
    task automatic bus_write(input logic [23:1] a, input logic [7:0] d);
        bus.asn  = 1'b0;
        bus.dsn  = 2'b10;
        bus.dswn = 2'b10;
        bus.addr = a;
        bus.dout = {8'h00, d};
        @(negedge clk);
        bus_idle();
    endtask

    task automatic cpu_write(input logic [4:0] idx, input logic [7:0] d);
        bus_write({REG_TOP, 10'd0, idx}, d);
    endtask

    task automatic mcu_write(input logic [4:0] idx, input logic [7:0] d);
        mcu_addr = {11'd0, idx};
        mcu_dout = d;
        // two sync flops before the address is used
        repeat (3) @(negedge clk);
        mcu_wr = 1'b1;
        @(negedge clk);
        mcu_wr = 1'b0;
    endtask

    // lowest index with matching top bits wins
    function automatic logic [7:0] expected_active(input logic [23:1] a, input logic [2:0] f);
        int width;
        if (f == 3'b111) begin
            return 8'h00;
        end
        for (int r = 0; r < `MAP_REGIONS; r++) begin
            case (reg_size[r][1:0])
                2'd0: width = 8;
                2'd1: width = 7;
                2'd2: width = 5;
                default: width = 3;
            endcase
            if ((a[23:16] >> (8 - width)) == (reg_base[r] >> (8 - width))) begin
                return 8'h01 << r;
            end
        end
        return 8'h00;
    endfunction

    task automatic run_mailbox();
        start_test("mailbox");
        snd_val = 8'($random(seed));
        cpu_write(`MAP_REG_SOUND, snd_val);
        #SETTLE;
        check_val("sndmap_dout", snd_val, sndmap_dout);
        check_val("sndmap_obf set", 1, sndmap_obf);
        @(negedge clk);
        sndmap_rd = 1'b1;
        @(negedge clk);
        sndmap_rd = 1'b0;
        #SETTLE;
        check_val("sndmap_obf cleared", 0, sndmap_obf);
        @(negedge clk);
        cpu_write(`MAP_REG_CTRL, 8'h02);
        #SETTLE;
        check_val("cpu_haltn", 0, cpu_haltn);
        @(negedge clk);
        cpu_write(`MAP_REG_CTRL, 8'h01);
        #SETTLE;
        check_val("cpu_haltn", 1, cpu_haltn);
        // only one falling edge since the write
        check_val("cpu_rst early", 0, cpu_rst);
        @(negedge clk);
        #SETTLE;
        check_val("cpu_rst", 1, cpu_rst);
        @(negedge clk);
        cpu_write(`MAP_REG_CTRL, 8'h00);
        @(negedge clk);
        #SETTLE;
        check_val("cpu_rst released", 0, cpu_rst);
        finish_test();
    endtask

    task automatic run_decode();
        logic [23:1] a;
        logic [2:0]  f;
        int          pick;
        start_test("decode");
        for (int r = 0; r < `MAP_REGIONS; r++) begin
            reg_size[r] = 8'($random(seed));
            reg_base[r] = 8'($random(seed)) & 8'h7f;
            cpu_write(5'(`MAP_REG_REGION + 2 * r), reg_size[r]);
            cpu_write(5'(`MAP_REG_REGION + 2 * r + 1), reg_base[r]);
        end
        for (int i = 0; i < N_ADDR; i++) begin
            a    = 23'($random(seed));
            f    = 3'($random(seed));
            pick = $unsigned($random(seed)) % (2 * `MAP_REGIONS);
            // half the draws aim at a programmed base
            if (pick < `MAP_REGIONS) begin
                a[23:16] = reg_base[pick];
            end
            bus.addr = a;
            bus.fc   = f;
            #SETTLE;
            check_val("active", expected_active(a, f), active);
            @(negedge clk);
        end
        bus.addr = {reg_base[0], 15'd0};
        bus.fc   = 3'b111;
        #SETTLE;
        check_val("active on fc 7", 0, active);
        @(negedge clk);
        bus_idle();
        bus_write({reg_base[0], 10'd0, 5'(`MAP_REG_SOUND)}, ~snd_val);
        #SETTLE;
        check_val("write in region", snd_val, sndmap_dout);
        check_val("sndmap_obf", 0, sndmap_obf);
        finish_test();
    endtask

    task automatic dtack_cycle(input logic [1:0] code, input int busy_clks);
        int strobes;
        strobes = 0;
        cpu_write(`MAP_REG_REGION, {4'd0, code, 2'd0});
        // AS high for a clock ends the write cycle
        @(negedge clk);
        bus.asn  = 1'b0;
        bus.addr = {reg_base[0], 15'h0123};
        bus_busy = busy_clks > 0;
        repeat (busy_clks) begin
            @(posedge clk);
            #SETTLE;
            check_val("dtackn while busy", 1, cpu_dtackn);
        end
        if (busy_clks > 0) begin
            @(negedge clk);
            bus_busy = 1'b0;
        end
        repeat (8) begin
            @(posedge clk);
            if (cpu_cen) begin
                strobes++;
            end
            #SETTLE;
            check_val("dtackn", (strobes >= int'(code)) ? 0 : 1, cpu_dtackn);
        end
        @(negedge clk);
        bus.asn = 1'b1;
        @(posedge clk);
        #SETTLE;
        check_val("dtackn after AS", 1, cpu_dtackn);
        @(negedge clk);
        bus_idle();
    endtask

    task automatic run_dtack();
        start_test("dtack");
        dtack_cycle(2'd1, 0);
        dtack_cycle(2'd2, 0);
        dtack_cycle(2'd3, 0);
        dtack_cycle(2'd1, 6);
        finish_test();
    endtask

    task automatic indirect_cycle(input logic [7:0] cmd, input logic [23:1] exp_addr);
        cpu_write(`MAP_REG_CMD, cmd);
        #SETTLE;
        check_val("addr_out in pulse", exp_addr, addr_out);
        check_val("bus_din in pulse", {wd[0], wd[1]}, bus_din);
        @(negedge clk);
        #SETTLE;
        check_val("addr_out after", bus.addr, addr_out);
        check_val("bus_din after", bus.dout, bus_din);
        @(negedge clk);
    endtask

    task automatic run_indirect();
        start_test("indirect");
        for (int i = 0; i < 2; i++) begin
            wd[i] = 8'($random(seed));
            cpu_write(5'(`MAP_REG_WDATA_HI + i), wd[i]);
        end
        for (int i = 0; i < 3; i++) begin
            wa[i] = 8'($random(seed));
            ra[i] = 8'($random(seed));
            cpu_write(5'(`MAP_REG_WADDR + i), wa[i]);
            cpu_write(5'(`MAP_REG_RADDR + i), ra[i]);
        end
        indirect_cycle(8'd1, {wa[0][6:0], wa[1], wa[2]});
        indirect_cycle(8'd2, {ra[0][6:0], ra[1], ra[2]});
        finish_test();
    endtask

    task automatic run_interrupts();
        int clks;
        start_test("interrupt");
        vint = 1'b1;
        @(negedge clk);
        vint = 1'b0;
        #SETTLE;
        check_val("cpu_ipln request", 3'b011, cpu_ipln);
        check_val("mcu_intn", 2'b10, mcu_intn);
        // count pixel enables until the pulse ends
        clks = 0;
        while (!mcu_intn[0] && clks < 2 * `MAP_MCU_IRQ_LEN) begin
            @(posedge clk);
            if (pxl_cen) begin
                clks++;
            end
            #SETTLE;
        end
        if (!mcu_intn[0]) begin
            $display("mcu_intn[0] stayed low for %0d pixel enables", clks);
            errors++;
        end else begin
            check_val("mcu pulse length", `MAP_MCU_IRQ_LEN, clks);
        end
        @(negedge clk);
        bus.fc  = 3'b111;
        bus.asn = 1'b0;
        #SETTLE;
        check_val("cpu_vpan in ack", 0, cpu_vpan);
        @(negedge clk);
        bus_idle();
        #SETTLE;
        check_val("cpu_ipln after ack", 3'b111, cpu_ipln);
        check_val("cpu_vpan after ack", 1, cpu_vpan);
        finish_test();
    endtask

    task automatic run_takeover();
        logic [7:0] readback [4];
        start_test("takeover");
        // first strobe only hands the register file over
        mcu_write(`MAP_REG_IRQ, 8'h05);
        #SETTLE;
        check_val("cpu_ipln at takeover", 3'b111, cpu_ipln);
        @(negedge clk);
        mcu_write(`MAP_REG_IRQ, 8'h05);
        #SETTLE;
        check_val("cpu_ipln from MCU", 3'b101, cpu_ipln);
        @(negedge clk);
        mcu_write(`MAP_REG_CTRL, 8'h02);
        #SETTLE;
        check_val("cpu_haltn from MCU", 0, cpu_haltn);
        @(negedge clk);
        cpu_write(`MAP_REG_SOUND, ~snd_val);
        #SETTLE;
        check_val("CPU write after takeover", snd_val, sndmap_dout);
        readback[0] = wd[0];
        readback[1] = wd[1];
        // halt set, reset clear
        readback[2] = {6'h3f, 1'b0, 1'b1};
        readback[3] = snd_val;
        for (int s = 0; s < 4; s++) begin
            @(negedge clk);
            mcu_addr = 16'(s);
            repeat (3) @(negedge clk);
            #SETTLE;
            check_val("mcu_din", readback[s], mcu_din);
        end
        finish_test();
    endtask

    initial begin
        vint      = 1'b0;
        bus_busy  = 1'b0;
        sndmap_rd = 1'b0;
        mcu_wr    = 1'b0;
        mcu_addr  = '0;
        mcu_dout  = '0;
        bus_idle();
        @(negedge rst);
        run_mailbox();
        run_decode();
        run_dtack();
        run_indirect();
        run_interrupts();
        run_takeover();
        @(negedge clk);
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // watchdog sized from the test lengths
    initial begin
        repeat (LIMIT_CYC) @(posedge clk);
        $display("timeout: tests still running after %0d clock cycles", LIMIT_CYC);
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+include
src/mapper_pkg.sv
src/mapper_regs.sv
src/region_decode.sv
src/dtack_delay.sv
src/irq_ctrl.sv
src/bus_mapper.sv
bench/clk_gen.sv
bench/tb_bus_mapper.sv

// ==== include/mapper_defs.svh ====
// Mapper constants: register map, region count and MCU interrupt pulse length
`ifndef MAPPER_DEFS_SVH
`define MAPPER_DEFS_SVH

// programmable regions and register file depth
`define MAP_REGIONS       8
`define MAP_NREGS         32

// register indices
`define MAP_REG_WDATA_HI  0
`define MAP_REG_WDATA_LO  1
`define MAP_REG_CTRL      2
`define MAP_REG_SOUND     3
`define MAP_REG_IRQ       4
`define MAP_REG_CMD       5
`define MAP_REG_WADDR     7
`define MAP_REG_RADDR     10
// size at even offset, base at odd offset
`define MAP_REG_REGION    16

// MCU vblank pulse, in pixel enables
`define MAP_MCU_IRQ_LEN   255

`endif

// ==== src/bus_mapper.sv ====
// Bus mapper top: register file, region decode, DTACK and interrupts with address/data muxes
`timescale 1ns/100ps
`include "mapper_defs.svh"

module bus_mapper import mapper_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cpu_cen,
    input  logic        pxl_cen,
    input  logic        vint,
    input  logic        bus_busy,
    input  cpu_bus_t    bus,
    input  logic        sndmap_rd,
    input  logic [15:0] mcu_addr,
    input  logic [7:0]  mcu_dout,
    input  logic        mcu_wr,
    output logic        cpu_rst,
    output logic        cpu_haltn,
    output logic        cpu_dtackn,
    output logic        cpu_vpan,
    output logic [2:0]  cpu_ipln,
    output logic [7:0]  sndmap_dout,
    output logic        sndmap_obf,
    output logic [7:0]  mcu_din,
    output logic [1:0]  mcu_intn,
    output logic [23:1] addr_out,
    output logic [15:0] bus_din,
    output logic [7:0]  active
);

    region_cfg_t [`MAP_REGIONS-1:0] regions;
    logic        cpu_sel;
    logic        wrmem, rdmem;
    logic [23:1] rdaddr, wraddr;
    logic [15:0] wrdata;
    logic [2:0]  irq_level;
    logic        ctrl_rst, ctrl_halt;
    logic        int_ack;
    logic [1:0]  dtack_cyc;
    logic        rst_aux;

    mapper_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .bus         (bus),
        .none_active (active == '0),
        .mcu_addr    (mcu_addr),
        .mcu_dout    (mcu_dout),
        .mcu_wr      (mcu_wr),
        .sndmap_rd   (sndmap_rd),
        .int_ack     (int_ack),
        .cpu_sel     (cpu_sel),
        .regions     (regions),
        .wrmem       (wrmem),
        .rdmem       (rdmem),
        .rdaddr      (rdaddr),
        .wraddr      (wraddr),
        .wrdata      (wrdata),
        .sndmap_dout (sndmap_dout),
        .sndmap_obf  (sndmap_obf),
        .irq_level   (irq_level),
        .ctrl_rst    (ctrl_rst),
        .ctrl_halt   (ctrl_halt),
        .mcu_din     (mcu_din)
    );

    // indirect cycles replace the CPU address and data for one clock
    assign addr_out = rdmem ? rdaddr : (wrmem ? wraddr : bus.addr);
    assign bus_din  = (wrmem | rdmem) ? wrdata : bus.dout;

    region_decode u_decode (
        .addr_out  (addr_out),
        .fc        (bus.fc),
        .regions   (regions),
        .active    (active),
        .dtack_cyc (dtack_cyc)
    );

    dtack_delay u_dtack (
        .clk        (clk),
        .rst        (rst),
        .cpu_cen    (cpu_cen),
        .asn        (bus.asn),
        .bus_busy   (bus_busy),
        .dtack_cyc  (dtack_cyc),
        .cpu_dtackn (cpu_dtackn)
    );

    irq_ctrl u_irq (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .vint      (vint),
        .bus       (bus),
        .cpu_sel   (cpu_sel),
        .irq_level (irq_level),
        .int_ack   (int_ack),
        .cpu_ipln  (cpu_ipln),
        .cpu_vpan  (cpu_vpan),
        .mcu_intn  (mcu_intn)
    );

    // CPU reset retimed on the falling edge
    always_ff @(negedge clk) begin
        rst_aux <= ctrl_rst | rst;
        cpu_rst <= rst_aux;
    end

    assign cpu_haltn = ~ctrl_halt;

endmodule

// ==== src/dtack_delay.sv ====
// DTACK generator with one or two extra clock-enable wait steps per region
`timescale 1ns/100ps

module dtack_delay (
    input  logic       clk,
    input  logic       rst,
    input  logic       cpu_cen,
    input  logic       asn,
    input  logic       bus_busy,
    input  logic [1:0] dtack_cyc,
    output logic       cpu_dtackn
);

    logic dtackn1, dtackn2, dtackn3;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dtackn1 <= 1'b1;
            dtackn2 <= 1'b1;
            dtackn3 <= 1'b1;
        end else if (asn) begin
            // end of bus cycle
            dtackn1 <= 1'b1;
            dtackn2 <= 1'b1;
            dtackn3 <= 1'b1;
        end else if (cpu_cen) begin
            // busy only holds off the first stage
            if (!bus_busy) begin
                dtackn1 <= 1'b0;
            end
            dtackn2 <= dtackn1;
            dtackn3 <= dtackn2;
        end
    end

    // codes 0 and 1 take the base stage
    always_comb begin
        case (dtack_cyc)
            2'd3: cpu_dtackn = dtackn3;
            2'd2: cpu_dtackn = dtackn2;
            default: cpu_dtackn = dtackn1;
        endcase
    end

endmodule

// ==== src/irq_ctrl.sv ====
// Interrupt controller for the vblank edge, CPU request and acknowledge, and the MCU vblank pulse
`timescale 1ns/100ps
`include "mapper_defs.svh"

module irq_ctrl import mapper_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       pxl_cen,
    input  logic       vint,
    input  cpu_bus_t   bus,
    input  logic       cpu_sel,
    input  logic [2:0] irq_level,
    output logic       int_ack,
    output logic [2:0] cpu_ipln,
    output logic       cpu_vpan,
    output logic [1:0] mcu_intn
);

    logic       last_vint;
    logic       irqn;
    logic       mcu_vintn;
    logic [7:0] mcu_cnt;
    logic       vint_rise;

    // fc all ones with AS asserted
    assign int_ack   = (&bus.fc) & ~bus.asn;
    assign cpu_vpan  = ~int_ack;
    assign vint_rise = vint & ~last_vint;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_vint <= 1'b0;
            irqn      <= 1'b1;
            mcu_vintn <= 1'b1;
            mcu_cnt   <= '0;
        end else begin
            last_vint <= vint;
            if (int_ack) begin
                irqn <= 1'b1;
            end else if (vint_rise) begin
                irqn <= 1'b0;
            end
            // MCU pulse counts pixel enables down to zero
            if (mcu_cnt != 0 && pxl_cen) begin
                mcu_cnt <= mcu_cnt - 8'd1;
                // last enable of the pulse
                if (mcu_cnt == 8'd1) begin
                    mcu_vintn <= 1'b1;
                end
            end
            if (vint_rise) begin
                mcu_vintn <= 1'b0;
                mcu_cnt   <= 8'(`MAP_MCU_IRQ_LEN);
            end
        end
    end

    // level 4 request until the MCU owns the IRQ register
    assign cpu_ipln = cpu_sel ? {irqn, 2'b11} : irq_level;
    assign mcu_intn = {1'b1, mcu_vintn};

endmodule

// ==== src/mapper_pkg.sv ====
// Mapper types: register word views, region configuration and CPU bus bundle
package mapper_pkg;

    // size register layout
    typedef struct packed {
        logic [3:0] unused;
        logic [1:0] dtack;
        logic [1:0] size;
    } region_size_t;

    // one register byte, read raw or as a region size word
    typedef union packed {
        logic [7:0]   raw;
        region_size_t sz;
    } map_reg_u;

    // per-region setup as seen by the decoder
    typedef struct packed {
        logic [7:0] base;
        map_reg_u   size;
    } region_cfg_t;

    // 68000 bus signals, driven by the CPU side
    typedef struct packed {
        logic        asn;
        logic [1:0]  dsn;
        logic [1:0]  dswn;
        logic [2:0]  fc;
        logic [23:1] addr;
        logic [15:0] dout;
    } cpu_bus_t;

endpackage

// ==== src/mapper_regs.sv ====
// Mapper register file: CPU/MCU writes, mailbox flag, indirect cycle strobes and MCU readback
`timescale 1ns/100ps
`include "mapper_defs.svh"

module mapper_regs import mapper_pkg::*; (
    input  logic                              clk,
    input  logic                              rst,
    input  cpu_bus_t                          bus,
    input  logic                              none_active,
    input  logic [15:0]                       mcu_addr,
    input  logic [7:0]                        mcu_dout,
    input  logic                              mcu_wr,
    input  logic                              sndmap_rd,
    input  logic                              int_ack,
    output logic                              cpu_sel,
    output region_cfg_t [`MAP_REGIONS-1:0]    regions,
    output logic                              wrmem,
    output logic                              rdmem,
    output logic [23:1]                       rdaddr,
    output logic [23:1]                       wraddr,
    output logic [15:0]                       wrdata,
    output logic [7:0]                        sndmap_dout,
    output logic                              sndmap_obf,
    output logic [2:0]                        irq_level,
    output logic                              ctrl_rst,
    output logic                              ctrl_halt,
    output logic [7:0]                        mcu_din
);

    map_reg_u   mmr [`MAP_NREGS];
    logic [4:0] mcu_addr_m, mcu_addr_s;
    logic [4:0] asel;
    logic [7:0] din;
    logic       wren;
    logic [7:0] snd_latch;

    // MCU address crosses in from another clock
    always_ff @(posedge clk) begin
        mcu_addr_m <= mcu_addr[4:0];
        mcu_addr_s <= mcu_addr_m;
    end

    // write source, CPU until the MCU takes over
    assign asel = cpu_sel ? bus.addr[5:1] : mcu_addr_s;
    assign din  = cpu_sel ? bus.dout[7:0] : mcu_dout;
    assign wren = cpu_sel ? (~bus.asn & ~bus.dswn[0] & none_active) : mcu_wr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `MAP_NREGS; i++) begin
                mmr[i] <= '0;
            end
            cpu_sel    <= 1'b1;
            sndmap_obf <= 1'b0;
            wrmem      <= 1'b0;
            rdmem      <= 1'b0;
            snd_latch  <= '0;
        end else begin
            wrmem <= 1'b0;
            rdmem <= 1'b0;
            // takeover lasts until reset
            if (mcu_wr) begin
                cpu_sel <= 1'b0;
            end
            if (wren) begin
                mmr[asel].raw <= din;
                if (asel == `MAP_REG_SOUND) begin
                    sndmap_obf <= 1'b1;
                    snd_latch  <= din;
                end
                if (asel == `MAP_REG_CMD) begin
                    wrmem <= din[1:0] == 2'b01;
                    rdmem <= din[1:0] == 2'b10;
                end
            end
            // read beats a same-cycle write
            if (sndmap_rd) begin
                sndmap_obf <= 1'b0;
            end
            if (int_ack) begin
                mmr[`MAP_REG_IRQ].raw[2:0] <= 3'b111;
            end
        end
    end

    // region pairs start at MAP_REG_REGION
    always_comb begin
        for (int r = 0; r < `MAP_REGIONS; r++) begin
            regions[r].size = mmr[`MAP_REG_REGION + 2*r];
            regions[r].base = mmr[`MAP_REG_REGION + 2*r + 1].raw;
        end
    end

    assign wraddr = {mmr[`MAP_REG_WADDR].raw[6:0], mmr[`MAP_REG_WADDR+1].raw,
                     mmr[`MAP_REG_WADDR+2].raw};
    assign rdaddr = {mmr[`MAP_REG_RADDR].raw[6:0], mmr[`MAP_REG_RADDR+1].raw,
                     mmr[`MAP_REG_RADDR+2].raw};
    assign wrdata = {mmr[`MAP_REG_WDATA_HI].raw, mmr[`MAP_REG_WDATA_LO].raw};

    assign sndmap_dout = mmr[`MAP_REG_SOUND].raw;
    assign irq_level   = mmr[`MAP_REG_IRQ].raw[2:0];
    assign ctrl_rst    = mmr[`MAP_REG_CTRL].raw[0];
    assign ctrl_halt   = mmr[`MAP_REG_CTRL].raw[1];

    // MCU readback
    always_ff @(posedge clk) begin
        case (mcu_addr_s[1:0])
            2'd0: mcu_din <= mmr[`MAP_REG_WDATA_HI].raw;
            2'd1: mcu_din <= mmr[`MAP_REG_WDATA_LO].raw;
            // status: halt_n in bit 1, inverted reset in bit 0
            2'd2: mcu_din <= {6'b11_1111, ~ctrl_halt, ~ctrl_rst};
            default: mcu_din <= snd_latch;
        endcase
    end

endmodule

// ==== src/region_decode.sv ====
// Region decoder: priority base/size match giving a one-hot region vector and its DTACK code
`timescale 1ns/100ps
`include "mapper_defs.svh"

module region_decode import mapper_pkg::*; (
    input  logic [23:1]                    addr_out,
    input  logic [2:0]                     fc,
    input  region_cfg_t [`MAP_REGIONS-1:0] regions,
    output logic [7:0]                     active,
    output logic [1:0]                     dtack_cyc
);

    logic [`MAP_REGIONS-1:0] hit;

    // larger sizes compare fewer upper bits
    always_comb begin
        for (int r = 0; r < `MAP_REGIONS; r++) begin
            case (regions[r].size.sz.size)
                2'd0: hit[r] = addr_out[23:16] == regions[r].base;
                2'd1: hit[r] = addr_out[23:17] == regions[r].base[7:1];
                2'd2: hit[r] = addr_out[23:19] == regions[r].base[7:3];
                default: hit[r] = addr_out[23:21] == regions[r].base[7:5];
            endcase
        end
    end

    always_comb begin
        active    = '0;
        dtack_cyc = 2'd0;
        // walk down so the lowest index is written last
        for (int r = `MAP_REGIONS - 1; r >= 0; r--) begin
            if (hit[r]) begin
                active    = '0;
                active[r] = 1'b1;
                dtack_cyc = regions[r].size.sz.dtack;
            end
        end
        // interrupt acknowledge cycles map nowhere
        if (&fc) begin
            active    = '0;
            dtack_cyc = 2'd0;
        end
    end

endmodule
